// File: common/lms_pkg.sv
// LMS6002D sample definitions
`default_nettype none

package lms_pkg;

   // Chip data bus, one word per IQ phase
   parameter int LMS_DATA_W = 12;

   // Captured sample, bus word left-justified
   parameter int SAMPLE_W = 14;

   // Channels on the board
   parameter int DEFAULT_NUM_CH = 2;

   // Transmit multiplexer phase
   // The chip expects I with TXIQSEL low and Q with it high
   typedef enum logic
   {
      tx_phase_i = 1'b0,   // I word on the bus
      tx_phase_q = 1'b1    // Q word on the bus
   } tx_phase_t;

endpackage

`default_nettype wire

// File: common/spi_pkg.sv
// SPI chip-select definitions
`default_nettype none

package spi_pkg;

   // Select lines driven by the shared SPI master
   parameter int SPI_NUM_DEV = 4;

   // Bit position of each device in the select vector
   typedef enum logic [1:0]
   {
      spi_dev_dac  = 2'd0,   // Clock DAC
      spi_dev_lms1 = 2'd1,   // First transceiver
      spi_dev_lms2 = 2'd2,   // Second transceiver
      spi_dev_aux  = 2'd3    // Aux synthesizer header
   } spi_dev_t;

endpackage

`default_nettype wire

// File: hdl/lms_frontend_top.sv
// LMS6002D front end top level
`timescale 1ns/1ps
`default_nettype none

module lms_frontend_top
#(
   parameter int NUM_CH      = lms_pkg::DEFAULT_NUM_CH,
   parameter int NUM_SPI_DEV = spi_pkg::SPI_NUM_DEV
)
(
   input  wire                                    lms_clk,
   input  wire                                    rst_n_i,

   // Receive bus from the chips
   input  wire [NUM_CH*lms_pkg::LMS_DATA_W-1:0]   rx_data_i,
   input  wire [NUM_CH-1:0]                       rx_iqsel_i,
   output logic [NUM_CH*lms_pkg::SAMPLE_W-1:0]    rx_i_o,
   output logic [NUM_CH*lms_pkg::SAMPLE_W-1:0]    rx_q_o,

   // Transmit samples in, chip bus out
   input  wire [NUM_CH*lms_pkg::LMS_DATA_W-1:0]   tx_i_i,
   input  wire [NUM_CH*lms_pkg::LMS_DATA_W-1:0]   tx_q_i,
   output logic [NUM_CH*lms_pkg::LMS_DATA_W-1:0]  tx_data_o,
   output logic [NUM_CH-1:0]                      tx_iqsel_o,

   // Shared SPI master side
   input  wire                                    spi_sclk_i,
   input  wire                                    spi_mosi_i,
   input  wire [NUM_SPI_DEV-1:0]                  spi_sen_n_i,
   output logic                                   spi_miso_o,

   // Per-device SPI pins
   output logic [NUM_SPI_DEV-1:0]                 dev_sclk_o,
   output logic [NUM_SPI_DEV-1:0]                 dev_mosi_o,
   input  wire [NUM_SPI_DEV-1:0]                  dev_miso_i
);

   // Receive capture, one IQ register pair per channel
   lms_rx_capture
   #(
      .NUM_CH     (NUM_CH)
   )
   i_rx_capture
   (
      .lms_clk    (lms_clk),
      .rst_n_i    (rst_n_i),
      .rx_data_i  (rx_data_i),
      .rx_iqsel_i (rx_iqsel_i),
      .rx_i_o     (rx_i_o),
      .rx_q_o     (rx_q_o)
   );

   // Transmit interleave
   lms_tx_interleave
   #(
      .NUM_CH     (NUM_CH)
   )
   i_tx_interleave
   (
      .lms_clk    (lms_clk),
      .rst_n_i    (rst_n_i),
      .tx_i_i     (tx_i_i),
      .tx_q_i     (tx_q_i),
      .tx_data_o  (tx_data_o),
      .tx_iqsel_o (tx_iqsel_o)
   );

   // SPI gating needs no clock, zero latency
   lms_spi_fanout
   #(
      .NUM_SPI_DEV (NUM_SPI_DEV)
   )
   i_spi_fanout
   (
      .spi_sclk_i  (spi_sclk_i),
      .spi_mosi_i  (spi_mosi_i),
      .spi_sen_n_i (spi_sen_n_i),
      .dev_miso_i  (dev_miso_i),
      .dev_sclk_o  (dev_sclk_o),
      .dev_mosi_o  (dev_mosi_o),
      .spi_miso_o  (spi_miso_o)
   );

endmodule

`default_nettype wire

// File: hdl/lms_spi_fanout.sv
// SPI chip-select fan-out
`timescale 1ns/1ps
`default_nettype none

module lms_spi_fanout
#(
   parameter int NUM_SPI_DEV = 4
)
(
   input  wire                    spi_sclk_i,
   input  wire                    spi_mosi_i,
   input  wire [NUM_SPI_DEV-1:0]  spi_sen_n_i,   // Active low selects
   input  wire [NUM_SPI_DEV-1:0]  dev_miso_i,
   output logic [NUM_SPI_DEV-1:0] dev_sclk_o,
   output logic [NUM_SPI_DEV-1:0] dev_mosi_o,
   output logic                   spi_miso_o
);

   logic [NUM_SPI_DEV-1:0] dev_sel;

   assign dev_sel = ~spi_sen_n_i;

   genvar dev;

   // Unselected devices see a quiet bus
   generate
      for (dev = 0; dev < NUM_SPI_DEV; dev++)
      begin : gen_dev
         assign dev_sclk_o[dev] = dev_sel[dev] & spi_sclk_i;
         assign dev_mosi_o[dev] = dev_sel[dev] & spi_mosi_i;
      end
   endgenerate

   // Only selected devices may pull the return line high
   assign spi_miso_o = |(dev_sel & dev_miso_i);

endmodule

`default_nettype wire

// File: lms_rx/lms_rx_capture.sv
// LMS receive bus capture
`timescale 1ns/1ps
`default_nettype none

module lms_rx_capture
#(
   parameter int NUM_CH = 2
)
(
   input  wire                                    lms_clk,
   input  wire                                    rst_n_i,
   input  wire [NUM_CH*lms_pkg::LMS_DATA_W-1:0]   rx_data_i,
   input  wire [NUM_CH-1:0]                       rx_iqsel_i,
   output logic [NUM_CH*lms_pkg::SAMPLE_W-1:0]    rx_i_o,
   output logic [NUM_CH*lms_pkg::SAMPLE_W-1:0]    rx_q_o
);

   localparam int DATA_W = lms_pkg::LMS_DATA_W;
   localparam int SMP_W  = lms_pkg::SAMPLE_W;
   localparam int PAD_W  = SMP_W - DATA_W;   // Zero bits below the word

   genvar ch;

   generate
      for (ch = 0; ch < NUM_CH; ch++)
      begin : gen_ch
         logic [DATA_W-1:0] word;
         logic [SMP_W-1:0]  sample;
         logic [SMP_W-1:0]  i_q;
         logic [SMP_W-1:0]  q_q;

         assign word = rx_data_i[ch*DATA_W +: DATA_W];

         // Left-justify so full scale stays at the top of the sample
         assign sample = {word, {PAD_W{1'b0}}};

         // IQSEL high marks an I word, low a Q word
         always_ff @(posedge lms_clk)
         begin
            if (!rst_n_i)
            begin
               i_q <= '0;
               q_q <= '0;
            end
            else if (rx_iqsel_i[ch])
            begin
               i_q <= sample;   // Q holds
            end
            else
            begin
               q_q <= sample;   // I holds
            end
         end

         assign rx_i_o[ch*SMP_W +: SMP_W] = i_q;
         assign rx_q_o[ch*SMP_W +: SMP_W] = q_q;
      end
   endgenerate

endmodule

`default_nettype wire

// File: lms_tx/lms_tx_interleave.sv
// LMS transmit IQ interleaver
`timescale 1ns/1ps
`default_nettype none

module lms_tx_interleave
#(
   parameter int NUM_CH = 2
)
(
   input  wire                                    lms_clk,
   input  wire                                    rst_n_i,
   input  wire [NUM_CH*lms_pkg::LMS_DATA_W-1:0]   tx_i_i,
   input  wire [NUM_CH*lms_pkg::LMS_DATA_W-1:0]   tx_q_i,
   output logic [NUM_CH*lms_pkg::LMS_DATA_W-1:0]  tx_data_o,
   output logic [NUM_CH-1:0]                      tx_iqsel_o
);

   localparam int DATA_W = lms_pkg::LMS_DATA_W;

   genvar ch;

   generate
      for (ch = 0; ch < NUM_CH; ch++)
      begin : gen_ch
         lms_pkg::tx_phase_t phase;
         logic [DATA_W-1:0]  data_q;
         logic               iqsel_q;

         // One word per cycle, so each of I and Q gets every other cycle
         always_ff @(posedge lms_clk)
         begin
            if (!rst_n_i)
            begin
               phase   <= lms_pkg::tx_phase_i;
               data_q  <= '0;
               iqsel_q <= 1'b0;
            end
            else
            begin
               case (phase)
                  lms_pkg::tx_phase_i:
                  begin
                     data_q  <= tx_i_i[ch*DATA_W +: DATA_W];
                     iqsel_q <= 1'b0;   // I word
                     phase   <= lms_pkg::tx_phase_q;
                  end
                  lms_pkg::tx_phase_q:
                  begin
                     data_q  <= tx_q_i[ch*DATA_W +: DATA_W];
                     iqsel_q <= 1'b1;   // Q word
                     phase   <= lms_pkg::tx_phase_i;
                  end
               endcase
            end
         end

         // Select travels with its word, both registered
         assign tx_data_o[ch*DATA_W +: DATA_W] = data_q;
         assign tx_iqsel_o[ch]                 = iqsel_q;
      end
   endgenerate

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the LMS front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -j 0 \
   -f vlog.f \
   --top-module tb_lms_frontend \
   -o sim_lms_frontend > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_lms_frontend > sim.log 2>&1

cat sim.log

grep -q "Test completed successfully" sim.log && echo "RESULT: PASS" || {
   echo "RESULT: FAIL"
   exit 1
}

// File: tests/lms_frontend_assert.sv
// Front end protocol assertions
`timescale 1ns/1ps
`default_nettype none

module lms_frontend_assert
#(
   parameter int NUM_CH      = 2,
   parameter int NUM_SPI_DEV = 4
)
(
   input wire                   lms_clk,
   input wire                   rst_n_i,
   input wire [NUM_CH-1:0]      tx_iqsel_o,
   input wire [NUM_SPI_DEV-1:0] spi_sen_n_i,
   input wire [NUM_SPI_DEV-1:0] dev_sclk_o
);

   genvar ch;
   genvar dev;

   generate
      for (ch = 0; ch < NUM_CH; ch++)
      begin : gen_ch
         // Select alternates every cycle once the first word is out
         assert property (@(posedge lms_clk) disable iff (!rst_n_i)
            $past(rst_n_i) && $past(rst_n_i, 2) |-> tx_iqsel_o[ch] != $past(tx_iqsel_o[ch]))
            else $error("tx_iqsel_o[%0d] did not toggle", ch);

         // First word after reset is an I word
         assert property (@(posedge lms_clk) $rose(rst_n_i) |=> !tx_iqsel_o[ch])
            else $error("tx_iqsel_o[%0d] high in first cycle after reset", ch);
      end

      for (dev = 0; dev < NUM_SPI_DEV; dev++)
      begin : gen_dev
         assert property (@(posedge lms_clk) disable iff (!rst_n_i)
            spi_sen_n_i[dev] |-> !dev_sclk_o[dev])   // Idle device sees no clock
            else $error("dev_sclk_o[%0d] active while deselected", dev);
      end
   endgenerate

endmodule

bind lms_frontend_top lms_frontend_assert
#(
   .NUM_CH      (NUM_CH),
   .NUM_SPI_DEV (NUM_SPI_DEV)
)
i_frontend_assert
(
   .lms_clk     (lms_clk),
   .rst_n_i     (rst_n_i),
   .tx_iqsel_o  (tx_iqsel_o),
   .spi_sen_n_i (spi_sen_n_i),
   .dev_sclk_o  (dev_sclk_o)
);

`default_nettype wire

// File: tests/tb_lms_frontend.sv
// LMS front end testbench
`timescale 1ns/1ps
`default_nettype none

module tb_lms_frontend;

   localparam int NUM_CH  = lms_pkg::DEFAULT_NUM_CH;
   localparam int NUM_DEV = spi_pkg::SPI_NUM_DEV;
   localparam int DATA_W  = lms_pkg::LMS_DATA_W;
   localparam int SMP_W   = lms_pkg::SAMPLE_W;
   // Tests take about 150 cycles with reset
   localparam int TIMEOUT_CYCLES = 2000;

   logic                       lms_clk;
   logic                       rst_n_i;
   logic [NUM_CH*DATA_W-1:0]   rx_data_i;
   logic [NUM_CH-1:0]          rx_iqsel_i;
   logic [NUM_CH*DATA_W-1:0]   tx_i_i;
   logic [NUM_CH*DATA_W-1:0]   tx_q_i;
   logic                       spi_sclk_i;
   logic                       spi_mosi_i;
   logic [NUM_DEV-1:0]         spi_sen_n_i;
   logic [NUM_DEV-1:0]         dev_miso_i;
   wire  [NUM_CH*SMP_W-1:0]    rx_i_o;
   wire  [NUM_CH*SMP_W-1:0]    rx_q_o;
   wire  [NUM_CH*DATA_W-1:0]   tx_data_o;
   wire  [NUM_CH-1:0]          tx_iqsel_o;
   wire                        spi_miso_o;
   wire  [NUM_DEV-1:0]         dev_sclk_o;
   wire  [NUM_DEV-1:0]         dev_mosi_o;

   integer           seed;
   int               cycle_cnt;
   logic [SMP_W-1:0] exp_rx_i [NUM_CH];   // Last I word per channel
   logic [SMP_W-1:0] exp_rx_q [NUM_CH];

   lms_frontend_top i_lms_frontend_top
   (
      .lms_clk     (lms_clk),
      .rst_n_i     (rst_n_i),
      .rx_data_i   (rx_data_i),
      .rx_iqsel_i  (rx_iqsel_i),
      .rx_i_o      (rx_i_o),
      .rx_q_o      (rx_q_o),
      .tx_i_i      (tx_i_i),
      .tx_q_i      (tx_q_i),
      .tx_data_o   (tx_data_o),
      .tx_iqsel_o  (tx_iqsel_o),
      .spi_sclk_i  (spi_sclk_i),
      .spi_mosi_i  (spi_mosi_i),
      .spi_sen_n_i (spi_sen_n_i),
      .spi_miso_o  (spi_miso_o),
      .dev_sclk_o  (dev_sclk_o),
      .dev_mosi_o  (dev_mosi_o),
      .dev_miso_i  (dev_miso_i)
   );

   initial
   begin
      lms_clk = 1'b0;
      forever #4 lms_clk = ~lms_clk;   // 8 ns period
   end

   always @(posedge lms_clk)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: simulation ran past %0d clock cycles", TIMEOUT_CYCLES);
         $display("Test failed");
         $fatal(1, "Run stopped by cycle limit");
      end
   end

   task automatic check_value(input string test_name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected)
      begin
         $display("ERROR: %s expected 0x%0h actual 0x%0h", test_name, expected, actual);
         $display("Test failed");
         $fatal(1, "Mismatch in %s", test_name);
      end
   endtask

   task automatic apply_reset;
      rst_n_i <= 1'b0;
      repeat (5) @(posedge lms_clk);
      rst_n_i <= 1'b1;
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
         exp_rx_i[ch] = '0;
         exp_rx_q[ch] = '0;
      end
   endtask

   // Model of the capture registers for the word sampled at this edge
   task automatic rx_model_update;
      logic [DATA_W-1:0] word;
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
         word = rx_data_i[ch*DATA_W +: DATA_W];
         if (rx_iqsel_i[ch])
            exp_rx_i[ch] = {word, 2'b00};
         else
            exp_rx_q[ch] = {word, 2'b00};
      end
   endtask

   task automatic check_rx(input string test_name);
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
         check_value($sformatf("%s ch%0d I", test_name, ch), 32'(exp_rx_i[ch]),
                     32'(rx_i_o[ch*SMP_W +: SMP_W]));
         check_value($sformatf("%s ch%0d Q", test_name, ch), 32'(exp_rx_q[ch]),
                     32'(rx_q_o[ch*SMP_W +: SMP_W]));
      end
   endtask

   task automatic reset_state_test;
      @(negedge lms_clk);
      check_value("reset rx_i", 32'h0, 32'(rx_i_o));
      check_value("reset rx_q", 32'h0, 32'(rx_q_o));
      check_value("reset tx_data", 32'h0, 32'(tx_data_o));
      check_value("reset tx_iqsel", 32'h0, 32'(tx_iqsel_o));
   endtask

   task automatic rx_demux_test;
      for (int n = 0; n < 50; n++)
      begin
         @(posedge lms_clk);
         rx_model_update();
         for (int ch = 0; ch < NUM_CH; ch++)
            rx_data_i[ch*DATA_W +: DATA_W] <= DATA_W'($random(seed));
         rx_iqsel_i <= NUM_CH'($random(seed));
         @(negedge lms_clk);
         check_rx("rx demux");
      end
   endtask

   task automatic rx_hold_test;
      logic [SMP_W-1:0] q_before [NUM_CH];
      @(posedge lms_clk);
      rx_model_update();
      rx_iqsel_i <= '1;   // I only from the next edge on
      @(negedge lms_clk);
      check_rx("rx hold entry");
      for (int ch = 0; ch < NUM_CH; ch++)
         q_before[ch] = exp_rx_q[ch];
      for (int n = 0; n < 8; n++)
      begin
         @(posedge lms_clk);
         rx_model_update();
         for (int ch = 0; ch < NUM_CH; ch++)
            rx_data_i[ch*DATA_W +: DATA_W] <= DATA_W'($random(seed));
         @(negedge lms_clk);
         check_rx("rx hold");
         for (int ch = 0; ch < NUM_CH; ch++)
            check_value($sformatf("rx hold ch%0d Q kept", ch), 32'(q_before[ch]),
                        32'(rx_q_o[ch*SMP_W +: SMP_W]));
      end
   endtask

   task automatic tx_interleave_test;
      logic [NUM_CH*DATA_W-1:0] sent_i;
      logic [NUM_CH*DATA_W-1:0] sent_q;
      logic [DATA_W-1:0]        exp_word;
      logic                     exp_sel;
      @(negedge lms_clk);
      exp_sel = tx_iqsel_o[0];   // Phase reference, alternates from here on
      for (int n = 0; n < 40; n++)
      begin
         @(posedge lms_clk);
         sent_i = tx_i_i;   // Words taken at this edge
         sent_q = tx_q_i;
         for (int ch = 0; ch < NUM_CH; ch++)
         begin
            tx_i_i[ch*DATA_W +: DATA_W] <= DATA_W'($random(seed));
            tx_q_i[ch*DATA_W +: DATA_W] <= DATA_W'($random(seed));
         end
         @(negedge lms_clk);
         exp_sel = !exp_sel;
         for (int ch = 0; ch < NUM_CH; ch++)
         begin
            check_value($sformatf("tx ch%0d iqsel", ch), 32'(exp_sel),
                        32'(tx_iqsel_o[ch]));
            exp_word = tx_iqsel_o[ch] ? sent_q[ch*DATA_W +: DATA_W]
                                      : sent_i[ch*DATA_W +: DATA_W];
            check_value($sformatf("tx ch%0d data", ch), 32'(exp_word),
                        32'(tx_data_o[ch*DATA_W +: DATA_W]));
         end
      end
   endtask

   task automatic spi_gating_test;
      spi_pkg::spi_dev_t  dev_list [4];
      logic [NUM_DEV-1:0] one_hot;
      dev_list = '{spi_pkg::spi_dev_dac, spi_pkg::spi_dev_lms1,
                   spi_pkg::spi_dev_lms2, spi_pkg::spi_dev_aux};
      for (int d = 0; d < 4; d++)
      begin
         one_hot = NUM_DEV'(1) << dev_list[d];
         for (int pat = 0; pat < 4; pat++)
         begin
            @(posedge lms_clk);
            spi_sen_n_i <= ~one_hot;
            spi_sclk_i  <= pat[0];
            spi_mosi_i  <= pat[1];
            @(negedge lms_clk);
            check_value($sformatf("spi sclk %s", dev_list[d].name()),
                        32'(pat[0] ? one_hot : '0), 32'(dev_sclk_o));
            check_value($sformatf("spi mosi %s", dev_list[d].name()),
                        32'(pat[1] ? one_hot : '0), 32'(dev_mosi_o));
         end
      end
      @(posedge lms_clk);
      spi_sen_n_i <= '1;   // Nobody selected
      spi_sclk_i  <= 1'b1;
      spi_mosi_i  <= 1'b1;
      dev_miso_i  <= '1;
      @(negedge lms_clk);
      check_value("spi idle sclk", 32'h0, 32'(dev_sclk_o));
      check_value("spi idle mosi", 32'h0, 32'(dev_mosi_o));
      check_value("spi idle miso", 32'h0, 32'(spi_miso_o));
   endtask

   task automatic miso_combine_test;
      logic [NUM_DEV-1:0] sen;
      logic [NUM_DEV-1:0] miso;
      logic               exp_miso;
      for (int n = 0; n < 30; n++)
      begin
         sen  = NUM_DEV'($random(seed));
         miso = NUM_DEV'($random(seed));
         exp_miso = 1'b0;
         for (int k = 0; k < NUM_DEV; k++)
            exp_miso = exp_miso | (!sen[k] & miso[k]);
         @(posedge lms_clk);
         spi_sen_n_i <= sen;
         dev_miso_i  <= miso;
         @(negedge lms_clk);
         check_value("miso combine", 32'(exp_miso), 32'(spi_miso_o));
      end
   endtask

   initial
   begin
      seed        = 32'hb5f3f0cf;
      cycle_cnt   = 0;
      rst_n_i     = 1'b0;
      rx_data_i   = '0;
      rx_iqsel_i  = '0;
      tx_i_i      = '0;
      tx_q_i      = '0;
      spi_sclk_i  = 1'b0;
      spi_mosi_i  = 1'b0;
      spi_sen_n_i = '1;
      dev_miso_i  = '0;
      apply_reset();
      reset_state_test();
      rx_demux_test();
      rx_hold_test();
      tx_interleave_test();
      spi_gating_test();
      miso_combine_test();
      $display("Test completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
common/lms_pkg.sv
common/spi_pkg.sv
lms_rx/lms_rx_capture.sv
lms_tx/lms_tx_interleave.sv
hdl/lms_spi_fanout.sv
hdl/lms_frontend_top.sv
tests/lms_frontend_assert.sv
tests/tb_lms_frontend.sv
